// File: mdc.f
mdc_pkg.sv
hamming_decoder.sv
frame_capture.sv
det_engine.sv
mdc.sv
mdc_assert.sv
mdc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the mdc testbench with Verilator.
# Exit status is zero only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module mdc_tb -f mdc.f -o mdc_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/mdc_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation run exited with status $run_status"
    exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
    exit 0
fi
exit 1

// File: mdc_tb.sv
/*
 * Testbench for the matrix determinant calculator. Encodes random and
 * extreme matrices as Hamming code words, optionally flips one bit per
 * word, and streams them into the DUT. A concurrent assertion compares
 * out_data against a reference model whenever out_valid is high.
 */
`timescale 1ns/1ps
`default_nettype none

module mdc_tb;

    localparam int NUM_FRAMES  = 11;
    localparam int CYCLE_LIMIT = NUM_FRAMES * (16 + 12 + 4) + 100;
    localparam logic [31:0] LFSR_SEED = 32'd99815;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic                            clk;
    logic                            rst_n;
    logic                            in_valid;
    logic [mdc_pkg::CODE_DATA_W-1:0] in_data;
    logic [mdc_pkg::CODE_MODE_W-1:0] in_mode;
    logic                            out_valid;
    mdc_pkg::result_u                out_data;

    mdc_pkg::result_u exp_q;
    logic [31:0]      lfsr_state;
    int               matrix_val [mdc_pkg::MAT_N][mdc_pkg::MAT_N];
    int               mismatch_cnt = 0;
    int               check_err_cnt = 0;
    int               pulse_cnt = 0;
    int               cycle_cnt = 0;
    int               test_cnt = 0;
    int               test_fail_cnt = 0;
    int               pulse_base;
    int               err_base;

    mdc i_mdc (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_mode   (in_mode),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    always #20 clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (rst_n && out_valid) begin
            pulse_cnt <= pulse_cnt + 1;
        end
    end

    check_result: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (out_data == exp_q))
    else begin
        $display("MISMATCH at %0t: out_data %h, expected %h", $time, $sampled(out_data),
                 $sampled(exp_q));
        mismatch_cnt++;
    end

    // ====================
    // Random source
    // ====================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    // ====================
    // Hamming encoder
    // ====================
    // Position 1 is the MSB, parity at positions 1, 2, 4 and 8
    function automatic logic [14:0] hamming_encode(input logic [10:0] data, input int dw);
        logic [14:0] code;
        int          cw;
        int          k;
        int          syn;
        cw = dw + 4;
        k = dw - 1;
        code = '0;
        syn = 0;
        for (int p = 1; p <= cw; p++) begin
            if ((p & (p - 1)) != 0) begin
                code[cw-p] = data[k];
                k--;
            end
        end
        for (int p = 1; p <= cw; p++) begin
            if (code[cw-p]) begin
                syn ^= p;
            end
        end
        for (int i = 0; i < 4; i++) begin
            if (syn[i]) begin
                code[cw-(1 << i)] = 1'b1;
            end
        end
        return code;
    endfunction

    function automatic logic [14:0] flip_random_bit(input logic [14:0] code, input int cw);
        logic [14:0] res;
        int          pos;
        res = code;
        pos = random_bits(4) % cw + 1;
        res[cw-pos] = ~res[cw-pos];
        return res;
    endfunction

    // ====================
    // Reference model
    // ====================
    function automatic longint minor_of(input int r0, input int r1, input int c0, input int c1);
        return longint'(matrix_val[r0][c0]) * matrix_val[r1][c1]
             - longint'(matrix_val[r0][c1]) * matrix_val[r1][c0];
    endfunction

    // Cofactor expansion along the top row of the sub-matrix at (r, c)
    function automatic longint det3_of(input int r, input int c);
        return longint'(matrix_val[r][c]) * minor_of(r + 1, r + 2, c + 1, c + 2)
             - longint'(matrix_val[r][c+1]) * minor_of(r + 1, r + 2, c, c + 2)
             + longint'(matrix_val[r][c+2]) * minor_of(r + 1, r + 2, c, c + 1);
    endfunction

    function automatic mdc_pkg::result_u expected_result(input logic [4:0] mode);
        mdc_pkg::result_u r;
        r = '0;
        if (mode == mdc_pkg::MODE_2X2) begin
            for (int i = 0; i < 3; i++) begin
                for (int j = 0; j < 3; j++) begin
                    r.minors[i*3+j] = mdc_pkg::minor_t'(minor_of(i, i + 1, j, j + 1));
                end
            end
        end else if (mode == mdc_pkg::MODE_3X3) begin
            for (int k = 0; k < 4; k++) begin
                r.dets.det[k] = mdc_pkg::det3_t'(det3_of(k / 2, k % 2));
            end
        end
        return r;
    endfunction

    function automatic void fill_random();
        for (int r = 0; r < mdc_pkg::MAT_N; r++) begin
            for (int c = 0; c < mdc_pkg::MAT_N; c++) begin
                matrix_val[r][c] = random_bits(11) - 1024;
            end
        end
    endfunction

    function automatic void fill_extreme();
        for (int r = 0; r < mdc_pkg::MAT_N; r++) begin
            for (int c = 0; c < mdc_pkg::MAT_N; c++) begin
                matrix_val[r][c] = (random_bits(1) != 0) ? 1023 : -1024;
            end
        end
    endfunction

    // ====================
    // Stimulus
    // ====================
    task automatic send_frame(input logic [4:0] mode, input bit corrupt);
        logic [14:0] code;
        logic [14:0] mode_code;
        @(posedge clk);
        exp_q <= expected_result(mode);
        mode_code = hamming_encode(11'(mode), 5);
        if (corrupt) begin
            mode_code = flip_random_bit(mode_code, 9);
        end
        for (int idx = 0; idx < 16; idx++) begin
            code = hamming_encode(11'(matrix_val[idx/4][idx%4]), 11);
            if (corrupt) begin
                code = flip_random_bit(code, 15);
            end
            in_valid <= 1'b1;
            in_data  <= code;
            in_mode  <= mode_code[8:0];
            @(posedge clk);
        end
        in_valid <= 1'b0;
        in_data  <= '0;
    endtask

    task automatic run_frame(input logic [4:0] mode, input bit corrupt);
        send_frame(mode, corrupt);
        do begin
            @(posedge clk);
        end while (!out_valid);
    endtask

    task automatic start_test();
        pulse_base = pulse_cnt;
        err_base   = mismatch_cnt + check_err_cnt;
    endtask

    task automatic finish_test(input string name, input int frames);
        repeat (3) @(posedge clk);
        assert (pulse_cnt - pulse_base == frames)
        else begin
            $display("Test %s: expected %0d out_valid pulses but saw %0d", name, frames,
                     pulse_cnt - pulse_base);
            check_err_cnt++;
        end
        test_cnt++;
        if (mismatch_cnt + check_err_cnt == err_base) begin
            $display("Test %0d (%s): pass", test_cnt, name);
        end else begin
            $display("Test %0d (%s): fail", test_cnt, name);
            test_fail_cnt++;
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_data    = '0;
        in_mode    = '0;
        exp_q      = '0;
        lfsr_state = LFSR_SEED;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        start_test();
        repeat (2) begin
            fill_random();
            run_frame(mdc_pkg::MODE_2X2, 1'b0);
        end
        finish_test("2x2 clean", 2);

        start_test();
        repeat (2) begin
            fill_random();
            run_frame(mdc_pkg::MODE_3X3, 1'b0);
        end
        finish_test("3x3 clean", 2);

        // Expected values come from the clean matrix
        start_test();
        fill_random();
        run_frame(mdc_pkg::MODE_2X2, 1'b1);
        fill_random();
        run_frame(mdc_pkg::MODE_3X3, 1'b1);
        finish_test("single-bit errors", 2);

        start_test();
        fill_random();
        run_frame(mdc_pkg::MODE_4X4, 1'b0);
        finish_test("unsupported mode", 1);

        start_test();
        for (int f = 0; f < 4; f++) begin
            fill_extreme();
            run_frame((f % 2 == 0) ? mdc_pkg::MODE_2X2 : mdc_pkg::MODE_3X3, 1'b0);
        end
        finish_test("back-to-back extremes", 4);

        $display("Tests: %0d run, %0d failed; mismatches: %0d, other errors: %0d",
                 test_cnt, test_fail_cnt, mismatch_cnt, check_err_cnt);
        if (mismatch_cnt + check_err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mdc_assert.sv
/*
 * Protocol checks for the determinant calculator top level, bound
 * into every instance of mdc. Covers the out_valid pulse shape, zero
 * output data between results, and the one-frame-in-flight rule.
 */
`timescale 1ns/1ps
`default_nettype none

module mdc_assert (
    input wire logic              clk,
    input wire logic              rst_n,
    input wire logic              in_valid,
    input wire logic              out_valid,
    input wire mdc_pkg::result_u  out_data
);

    logic frame_pending;

    // Set by incoming elements, cleared by the result pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_pending <= 1'b0;
        end else if (in_valid) begin
            frame_pending <= 1'b1;
        end else if (out_valid) begin
            frame_pending <= 1'b0;
        end
    end

    single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |=> !out_valid)
    else $error("out_valid high for two consecutive cycles");

    zero_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> (out_data == '0))
    else $error("out_data not zero while out_valid is low");

    no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(in_valid) |-> !frame_pending)
    else $error("in_valid rose while a frame was still pending");

endmodule

bind mdc mdc_assert i_mdc_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .out_data  (out_data)
);

`default_nettype wire

// File: mdc.sv
/*
 * Matrix determinant calculator, top level. Mode and element code
 * words are corrected by two Hamming decoders, gathered into a frame
 * and handed to the determinant engine. Valid-only interface, one
 * frame in flight; the end of each frame is marked by out_valid.
 */
`timescale 1ns/1ps
`default_nettype none

module mdc (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    input  logic [mdc_pkg::CODE_DATA_W-1:0] in_data,
    input  logic [mdc_pkg::CODE_MODE_W-1:0] in_mode,
    output logic                            out_valid,
    output mdc_pkg::result_u                out_data
);

    logic [mdc_pkg::MODE_W-1:0] mode_dec;
    mdc_pkg::elem_t             elem_dec;
    mdc_pkg::frame_t            frame;
    logic                       frame_ready;

    // ====================
    // Input correction
    // ====================
    hamming_decoder #(
        .DATA_W (mdc_pkg::MODE_W)
    ) i_mode_dec (
        .code (in_mode),
        .data (mode_dec)
    );

    hamming_decoder #(
        .DATA_W (mdc_pkg::DATA_W)
    ) i_data_dec (
        .code (in_data),
        .data (elem_dec)
    );

    // ====================
    // Capture and compute
    // ====================
    frame_capture i_frame_capture (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .mode        (mode_dec),
        .elem        (elem_dec),
        .frame       (frame),
        .frame_ready (frame_ready)
    );

    det_engine i_det_engine (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame       (frame),
        .frame_ready (frame_ready),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

endmodule

`default_nettype wire

// File: det_engine.sv
/*
 * Determinant engine. On frame_ready it steps one shared 2x2 minor
 * datapath through the frame: nine minors in 2x2 mode, one per cycle,
 * or three weighted minors per 3x3 determinant in 3x3 mode. Any other
 * mode answers at once with zeros. out_valid marks the one cycle in
 * which out_data carries the result.
 */
`timescale 1ns/1ps
`default_nettype none

module det_engine (
    input  logic             clk,
    input  logic             rst_n,
    input  mdc_pkg::frame_t  frame,
    input  logic             frame_ready,
    output logic             out_valid,
    output mdc_pkg::result_u out_data
);

    logic             busy;
    logic [1:0]       grp_idx;   // Row pair in 2x2, sub-matrix in 3x3
    logic [1:0]       term_idx;  // Column pair in 2x2, cofactor term in 3x3
    logic             is_2x2;
    logic             is_3x3;
    logic             last_step;
    logic [3:0]       minor_slot;
    logic [1:0]       row_a;
    logic [1:0]       row_b;
    logic [1:0]       col_a;
    logic [1:0]       col_b;
    mdc_pkg::elem_t   e_aa;
    mdc_pkg::elem_t   e_ab;
    mdc_pkg::elem_t   e_ba;
    mdc_pkg::elem_t   e_bb;
    mdc_pkg::elem_t   top_weight;
    logic signed [2*mdc_pkg::DATA_W-1:0] prod_main;
    logic signed [2*mdc_pkg::DATA_W-1:0] prod_anti;
    mdc_pkg::minor_t  minor_val;
    mdc_pkg::det3_t   mac_term;
    mdc_pkg::det3_t   acc_next;
    mdc_pkg::det3_t   acc_q;
    mdc_pkg::result_u res_q;

    assign is_2x2     = (frame.mode == mdc_pkg::MODE_2X2);
    assign is_3x3     = (frame.mode == mdc_pkg::MODE_3X3);
    assign last_step  = (term_idx == 2'd2) && (grp_idx == (is_3x3 ? 2'd3 : 2'd2));
    assign minor_slot = {2'b00, grp_idx} * 4'd3 + {2'b00, term_idx};

    // ====================
    // Operand selection
    // ====================
    always_comb begin
        if (is_3x3) begin
            // Origin at (grp_idx[1], grp_idx[0]); minors use the two rows
            // below it and skip the column of the weight
            row_a      = {1'b0, grp_idx[1]} + 2'd1;
            row_b      = {1'b0, grp_idx[1]} + 2'd2;
            col_a      = {1'b0, grp_idx[0]} + ((term_idx == 2'd0) ? 2'd1 : 2'd0);
            col_b      = {1'b0, grp_idx[0]} + ((term_idx == 2'd2) ? 2'd1 : 2'd2);
            top_weight = frame.matrix[grp_idx[1]][{1'b0, grp_idx[0]} + term_idx];
        end else begin
            row_a      = grp_idx;
            row_b      = grp_idx + 2'd1;
            col_a      = term_idx;
            col_b      = term_idx + 2'd1;
            top_weight = '0;
        end
        e_aa = frame.matrix[row_a][col_a];
        e_ab = frame.matrix[row_a][col_b];
        e_ba = frame.matrix[row_b][col_a];
        e_bb = frame.matrix[row_b][col_b];
    end

    // ====================
    // Minor and MAC
    // ====================
    always_comb begin
        prod_main = e_aa * e_bb;
        prod_anti = e_ab * e_ba;
        minor_val = prod_main - prod_anti;
        mac_term  = top_weight * minor_val;
        // Middle cofactor carries the minus sign
        if (term_idx == 2'd1) begin
            mac_term = -mac_term;
        end
        acc_next = (term_idx == 2'd0) ? mac_term : acc_q + mac_term;
    end

    // ====================
    // Sequencing
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            out_valid <= 1'b0;
            grp_idx   <= '0;
            term_idx  <= '0;
        end else begin
            out_valid <= 1'b0;
            if (frame_ready) begin
                grp_idx  <= '0;
                term_idx <= '0;
                if (is_2x2 || is_3x3) begin
                    busy <= 1'b1;
                end else begin
                    out_valid <= 1'b1;
                end
            end else if (busy) begin
                if (last_step) begin
                    busy      <= 1'b0;
                    out_valid <= 1'b1;
                end
                if (term_idx == 2'd2) begin
                    term_idx <= '0;
                    grp_idx  <= grp_idx + 2'd1;
                end else begin
                    term_idx <= term_idx + 2'd1;
                end
            end
        end
    end

    // Result word, cleared per frame so pad bits and unsupported modes read zero
    always_ff @(posedge clk) begin
        if (frame_ready) begin
            res_q <= '0;
        end else if (busy) begin
            acc_q <= acc_next;
            if (!is_3x3) begin
                res_q.minors[minor_slot] <= minor_val;
            end else if (term_idx == 2'd2) begin
                res_q.dets.det[grp_idx] <= acc_next;
            end
        end
    end

    assign out_data = out_valid ? res_q : '0;

endmodule

`default_nettype wire

// File: frame_capture.sv
/*
 * Frame capture. Takes the decoded mode in the first valid cycle and
 * writes each decoded element into the matrix slot given by the
 * element count. frame_ready pulses for one cycle once all sixteen
 * elements are held; frame stays stable until the next frame starts.
 */
`timescale 1ns/1ps
`default_nettype none

module frame_capture (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  logic [mdc_pkg::MODE_W-1:0] mode,
    input  mdc_pkg::elem_t             elem,
    output mdc_pkg::frame_t            frame,
    output logic                       frame_ready
);

    localparam int ELEMS = mdc_pkg::MAT_N * mdc_pkg::MAT_N;
    localparam int CNT_W = $clog2(ELEMS);
    localparam int IDX_W = $clog2(mdc_pkg::MAT_N);

    logic [CNT_W-1:0]           elem_cnt;
    logic                       first_elem;
    logic                       last_elem;
    logic [mdc_pkg::MODE_W-1:0] mode_q;
    mdc_pkg::matrix_t           matrix_q;

    assign first_elem = (elem_cnt == '0);
    assign last_elem  = (elem_cnt == CNT_W'(ELEMS - 1));

    // ====================
    // Count and mode
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            elem_cnt    <= '0;
            mode_q      <= '0;
            frame_ready <= 1'b0;
        end else begin
            frame_ready <= in_valid && last_elem;
            if (in_valid) begin
                // Wraps to zero after the last element of the frame
                elem_cnt <= elem_cnt + 1'b1;
                if (first_elem) begin
                    mode_q <= mode;
                end
            end
        end
    end

    // ====================
    // Element storage
    // ====================
    // Upper count bits pick the row, lower bits the column
    always_ff @(posedge clk) begin
        if (in_valid) begin
            matrix_q[elem_cnt[CNT_W-1:IDX_W]][elem_cnt[IDX_W-1:0]] <= elem;
        end
    end

    assign frame = '{mode: mode_q, matrix: matrix_q};

endmodule

`default_nettype wire

// File: hamming_decoder.sv
/*
 * Single-error-correcting Hamming decoder. The code word MSB is
 * position 1 and parity sits at the power-of-two positions. Purely
 * combinational; DATA_W selects the payload width and the parity
 * width follows from it.
 */
`timescale 1ns/1ps
`default_nettype none

module hamming_decoder #(
    parameter int DATA_W = 11
) (
    input  logic [DATA_W+par_bits(DATA_W)-1:0] code,
    output logic [DATA_W-1:0]                  data
);

    // Smallest parity count that covers data plus parity positions
    function automatic int par_bits(int n);
        int p;
        p = 1;
        while ((1 << p) < n + p + 1) begin
            p++;
        end
        return p;
    endfunction

    localparam int PAR_W  = par_bits(DATA_W);
    localparam int CODE_W = DATA_W + PAR_W;

    logic [PAR_W-1:0]  syndrome;
    logic [CODE_W-1:0] fixed;

    // XOR of the positions of all set bits
    always_comb begin
        syndrome = '0;
        for (int p = 1; p <= CODE_W; p++) begin
            if (code[CODE_W-p]) begin
                syndrome ^= PAR_W'(p);
            end
        end
    end

    // Flip the flagged position; a syndrome past the word end is left alone
    always_comb begin
        fixed = code;
        if (syndrome != '0 && int'(syndrome) <= CODE_W) begin
            fixed[CODE_W-int'(syndrome)] = ~code[CODE_W-int'(syndrome)];
        end
    end

    // Data bits are the non-parity positions, MSB first
    always_comb begin
        int k;
        k = DATA_W - 1;
        data = '0;
        for (int p = 1; p <= CODE_W; p++) begin
            if ((p & (p - 1)) != 0) begin
                data[k] = fixed[CODE_W-p];
                k--;
            end
        end
    end

endmodule

`default_nettype wire

// File: mdc_pkg.sv
/*
 * Shared widths, mode codes and data types of the matrix
 * determinant calculator. Design and testbench files refer to
 * these by scoped name.
 */
`default_nettype none

package mdc_pkg;

    // ====================
    // Widths and codes
    // ====================
    localparam int DATA_W      = 11;
    localparam int CODE_DATA_W = 15;
    localparam int MODE_W      = 5;
    localparam int CODE_MODE_W = 9;
    localparam int MAT_N       = 4;

    // Mode codes after Hamming correction
    localparam logic [MODE_W-1:0] MODE_2X2 = 5'b00100;
    localparam logic [MODE_W-1:0] MODE_3X3 = 5'b00110;
    // Full 4x4 determinant is not built, this code yields a zero result
    localparam logic [MODE_W-1:0] MODE_4X4 = 5'b10110;

    // ====================
    // Data types
    // ====================
    typedef logic signed [DATA_W-1:0] elem_t;

    // Row-major, element [0][0] arrives first and sits in the top bits
    typedef elem_t [0:MAT_N-1][0:MAT_N-1] matrix_t;

    // One 2x2 determinant, product width plus one
    typedef logic signed [2*DATA_W:0] minor_t;

    // One 3x3 determinant, sign-extended so four fill the result word
    typedef logic signed [50:0] det3_t;

    typedef struct packed {
        logic [2:0]  pad;
        det3_t [0:3] det;
    } det_view_t;

    // Output word, read as nine minors or as four determinants
    typedef union packed {
        minor_t [0:8] minors;
        det_view_t    dets;
    } result_u;

    typedef struct packed {
        logic [MODE_W-1:0] mode;
        matrix_t           matrix;
    } frame_t;

endpackage

`default_nettype wire
